// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dram_sched
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_MSG = Simulation finished: PASS
SOURCES = $(wildcard hw/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "run passed" || (echo "run failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/bank_timing_tracker.sv ====
module bank_timing_tracker (
	input logic clk,
	input logic rst_n,
	issued_cmd_if.listen issued,
	output logic [dram_sched_pkg::bank_count-1:0] row_open,
	output dram_sched_pkg::row_t [dram_sched_pkg::bank_count-1:0] open_row,
	output logic [dram_sched_pkg::bank_count-1:0] act_ok,
	output logic [dram_sched_pkg::bank_count-1:0] col_ok,
	output logic [dram_sched_pkg::bank_count-1:0] pre_ok,
	output logic [dram_sched_pkg::bank_group_count-1:0] bg_act_ok,
	output logic bus_col_ok,
	output logic bus_idle,
	output logic refresh_ready,
	output logic refresh_due
);
	import dram_sched_pkg::*;

	// counters restart on the registered command, so each limit is two short of the spacing
	localparam int act_sat = act_to_act_same_bank - 2;
	localparam int rd_sat = rd_to_pre - 2;
	localparam int wr_sat = wr_to_pre - 2;
	localparam int pre_sat = pre_to_act - 2;
	localparam int bg_sat = act_to_act_diff_bank - 2;
	localparam int bus_rd_sat = burst_time + rd_to_data + col_to_col - 2;
	localparam int bus_wr_sat = burst_time + wr_to_data + col_to_col - 2;
	localparam int ref_done_sat = wait_after_refresh - 2;
	localparam int ref_int_sat = max_refresh_time - 2;

	typedef logic [$clog2(act_sat + 1)-1:0] act_cnt_t;
	typedef logic [$clog2(rd_sat + 1)-1:0] rd_cnt_t;
	typedef logic [$clog2(wr_sat + 1)-1:0] wr_cnt_t;
	typedef logic [$clog2(pre_sat + 1)-1:0] pre_cnt_t;
	typedef logic [$clog2(bg_sat + 1)-1:0] bg_cnt_t;
	typedef logic [$clog2(bus_rd_sat + 1)-1:0] bus_rd_cnt_t;
	typedef logic [$clog2(bus_wr_sat + 1)-1:0] bus_wr_cnt_t;
	typedef logic [$clog2(ref_done_sat + 1)-1:0] ref_done_cnt_t;
	typedef logic [$clog2(ref_int_sat + 1)-1:0] ref_int_cnt_t;

	act_cnt_t act_cnt [bank_count];
	rd_cnt_t rd_cnt [bank_count];
	wr_cnt_t wr_cnt [bank_count];
	pre_cnt_t pre_cnt [bank_count];
	bg_cnt_t bg_cnt [bank_group_count];
	bus_rd_cnt_t bus_rd_cnt;
	bus_wr_cnt_t bus_wr_cnt;
	ref_done_cnt_t ref_done_cnt;
	ref_int_cnt_t ref_int_cnt;
	bank_id_t cmd_bank;

	assign cmd_bank = {issued.bg, issued.bank};

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < bank_count; i++) begin
				act_cnt[i] <= act_cnt_t'(act_sat - 5);   // hold off the first activate
				rd_cnt[i] <= rd_cnt_t'(rd_sat);
				wr_cnt[i] <= wr_cnt_t'(wr_sat);
				pre_cnt[i] <= pre_cnt_t'(pre_sat);
				row_open[i] <= 1'b0;
			end
			for (int g = 0; g < bank_group_count; g++) begin
				bg_cnt[g] <= bg_cnt_t'(bg_sat);
			end
			bus_rd_cnt <= bus_rd_cnt_t'(bus_rd_sat);
			bus_wr_cnt <= bus_wr_cnt_t'(bus_wr_sat);
			ref_done_cnt <= ref_done_cnt_t'(ref_done_sat);
			ref_int_cnt <= '0;
		end else begin
			for (int i = 0; i < bank_count; i++) begin
				if (cmd_bank == bank_id_t'(i) && issued.cmd == cmd_activate) begin
					act_cnt[i] <= '0;
				end else if (act_cnt[i] != act_cnt_t'(act_sat)) begin
					act_cnt[i] <= act_cnt[i] + 1'b1;
				end
				if (cmd_bank == bank_id_t'(i) && issued.cmd == cmd_read) begin
					rd_cnt[i] <= '0;
				end else if (rd_cnt[i] != rd_cnt_t'(rd_sat)) begin
					rd_cnt[i] <= rd_cnt[i] + 1'b1;
				end
				if (cmd_bank == bank_id_t'(i) && issued.cmd == cmd_write) begin
					wr_cnt[i] <= '0;
				end else if (wr_cnt[i] != wr_cnt_t'(wr_sat)) begin
					wr_cnt[i] <= wr_cnt[i] + 1'b1;
				end
				if (cmd_bank == bank_id_t'(i) && issued.cmd == cmd_precharge) begin
					pre_cnt[i] <= '0;
				end else if (pre_cnt[i] != pre_cnt_t'(pre_sat)) begin
					pre_cnt[i] <= pre_cnt[i] + 1'b1;
				end
				if (issued.cmd == cmd_refresh_all) begin
					row_open[i] <= 1'b0;   // refresh closes every row
				end else if (cmd_bank == bank_id_t'(i) && issued.cmd == cmd_activate) begin
					row_open[i] <= 1'b1;
				end else if (cmd_bank == bank_id_t'(i) && issued.cmd == cmd_precharge) begin
					row_open[i] <= 1'b0;
				end
			end
			for (int g = 0; g < bank_group_count; g++) begin
				if (issued.bg == bg_t'(g) && issued.cmd == cmd_activate) begin
					bg_cnt[g] <= '0;
				end else if (bg_cnt[g] != bg_cnt_t'(bg_sat)) begin
					bg_cnt[g] <= bg_cnt[g] + 1'b1;
				end
			end
			if (issued.cmd == cmd_read) begin
				bus_rd_cnt <= '0;
			end else if (bus_rd_cnt != bus_rd_cnt_t'(bus_rd_sat)) begin
				bus_rd_cnt <= bus_rd_cnt + 1'b1;
			end
			if (issued.cmd == cmd_write) begin
				bus_wr_cnt <= '0;
			end else if (bus_wr_cnt != bus_wr_cnt_t'(bus_wr_sat)) begin
				bus_wr_cnt <= bus_wr_cnt + 1'b1;
			end
			if (issued.cmd == cmd_refresh_all) begin
				ref_done_cnt <= '0;
				ref_int_cnt <= '0;
			end else begin
				if (ref_done_cnt != ref_done_cnt_t'(ref_done_sat)) begin
					ref_done_cnt <= ref_done_cnt + 1'b1;
				end
				if (ref_int_cnt != ref_int_cnt_t'(ref_int_sat)) begin
					ref_int_cnt <= ref_int_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issued.cmd == cmd_activate) begin
			open_row[cmd_bank] <= issued.row;
		end
	end

	always_comb begin
		for (int i = 0; i < bank_count; i++) begin
			act_ok[i] = !row_open[i] && act_cnt[i] == act_cnt_t'(act_sat)
				&& pre_cnt[i] == pre_cnt_t'(pre_sat);
			col_ok[i] = act_cnt[i] >= act_cnt_t'(act_to_col - 2);
			pre_ok[i] = act_cnt[i] >= act_cnt_t'(act_to_pre - 2)
				&& rd_cnt[i] == rd_cnt_t'(rd_sat) && wr_cnt[i] == wr_cnt_t'(wr_sat);
		end
		for (int g = 0; g < bank_group_count; g++) begin
			bg_act_ok[g] = bg_cnt[g] == bg_cnt_t'(bg_sat);
		end
	end

	assign bus_col_ok = bus_rd_cnt == bus_rd_cnt_t'(bus_rd_sat)
		&& bus_wr_cnt == bus_wr_cnt_t'(bus_wr_sat);
	// no burst left on the data bus
	assign bus_idle = bus_rd_cnt >= bus_rd_cnt_t'(burst_time + rd_to_data - 2)
		&& bus_wr_cnt >= bus_wr_cnt_t'(burst_time + wr_to_data - 2);
	assign refresh_ready = ref_done_cnt == ref_done_cnt_t'(ref_done_sat);
	assign refresh_due = ref_int_cnt == ref_int_cnt_t'(ref_int_sat);

endmodule

// ==== hw/burst_slot_table.sv ====
module burst_slot_table #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input dram_sched_pkg::req_kind_t req_kind,
	input dram_sched_pkg::bg_t req_bg,
	input dram_sched_pkg::bank_t req_bank,
	input dram_sched_pkg::row_t req_row,
	output logic req_ready,
	slot_status_if.tbl status,
	issued_cmd_if.listen issued
);
	import dram_sched_pkg::*;

	localparam int slot_w = $clog2(no_of_bursts);
	localparam int rd_ret = burst_time + rd_to_data;
	localparam int wr_ret = burst_time + wr_to_data;
	localparam int ret_w = $clog2(rd_ret > wr_ret ? rd_ret : wr_ret);

	typedef logic [slot_w-1:0] slot_idx_t;
	typedef logic [ret_w-1:0] ret_cnt_t;

	ret_cnt_t ret_cnt [no_of_bursts];   // data time left per slot
	slot_idx_t free_idx;
	logic any_empty;
	logic ready_en;                     // keeps req_ready low for one cycle after reset
	logic accept;
	logic col_issued;

	// lowest numbered empty slot wins
	always_comb begin
		any_empty = 1'b0;
		free_idx = '0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin
			if (status.state[i] == slot_empty) begin
				any_empty = 1'b1;
				free_idx = slot_idx_t'(i);
			end
		end
	end

	assign req_ready = ready_en && any_empty;
	assign accept = req_valid && req_ready;
	assign col_issued = (issued.cmd == cmd_read) || (issued.cmd == cmd_write);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			ready_en <= 1'b0;
			for (int i = 0; i < no_of_bursts; i++) begin
				status.state[i] <= slot_empty;
			end
		end else begin
			ready_en <= 1'b1;
			for (int i = 0; i < no_of_bursts; i++) begin
				case (status.state[i])
					slot_empty: begin
						if (accept && free_idx == slot_idx_t'(i)) begin
							status.state[i] <= slot_full;
						end
					end
					slot_full: begin
						if (col_issued && issued.slot == slot_idx_t'(i)) begin
							status.state[i] <= slot_returning;
						end
					end
					slot_returning: begin
						if (ret_cnt[i] == '0) begin
							status.state[i] <= slot_empty;   // data time is over
						end
					end
					default: status.state[i] <= slot_empty;
				endcase
			end
		end
	end

	// request fields and data countdown
	always_ff @(posedge clk) begin
		if (accept) begin
			status.kind[free_idx] <= req_kind;
			status.bg[free_idx] <= req_bg;
			status.bank[free_idx] <= req_bank;
			status.row[free_idx] <= req_row;
		end
		for (int i = 0; i < no_of_bursts; i++) begin
			if (col_issued && issued.slot == slot_idx_t'(i)) begin
				ret_cnt[i] <= (issued.cmd == cmd_read) ? ret_cnt_t'(rd_ret - 1)
					: ret_cnt_t'(wr_ret - 1);
			end else if (ret_cnt[i] != '0) begin
				ret_cnt[i] <= ret_cnt[i] - 1'b1;
			end
		end
	end

endmodule

// ==== hw/dram_cmd_scheduler.sv ====
module dram_cmd_scheduler #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,
	slot_status_if.sched status,
	input logic [dram_sched_pkg::bank_count-1:0] row_open,
	input dram_sched_pkg::row_t [dram_sched_pkg::bank_count-1:0] open_row,
	input logic [dram_sched_pkg::bank_count-1:0] act_ok,
	input logic [dram_sched_pkg::bank_count-1:0] col_ok,
	input logic [dram_sched_pkg::bank_count-1:0] pre_ok,
	input logic [dram_sched_pkg::bank_group_count-1:0] bg_act_ok,
	input logic bus_col_ok,
	input logic bus_idle,
	input logic refresh_ready,
	input logic refresh_due,
	issued_cmd_if.sched issued
);
	import dram_sched_pkg::*;

	localparam int slot_w = $clog2(no_of_bursts);

	typedef logic [slot_w-1:0] slot_idx_t;

	bank_id_t [no_of_bursts-1:0] slot_bank;
	logic [no_of_bursts-1:0] slot_hit;    // full slot whose row is open
	logic [bank_count-1:0] hit_pending;   // bank has a row hit waiting
	dram_cmd_t [no_of_bursts-1:0] slot_cmd;
	logic [no_of_bursts-1:0] cand;
	slot_idx_t rr_ptr;                    // slot after the last grant
	slot_idx_t idx;
	slot_idx_t pick;
	logic found;
	dram_cmd_t next_cmd;

	always_comb begin
		hit_pending = '0;
		for (int i = 0; i < no_of_bursts; i++) begin
			slot_bank[i] = {status.bg[i], status.bank[i]};
			slot_hit[i] = status.state[i] == slot_full && row_open[slot_bank[i]]
				&& open_row[slot_bank[i]] == status.row[i];
			if (slot_hit[i]) begin
				hit_pending[slot_bank[i]] = 1'b1;
			end
		end
	end

	// next legal command for every full slot
	always_comb begin
		for (int i = 0; i < no_of_bursts; i++) begin
			slot_cmd[i] = cmd_none;
			if (status.state[i] == slot_full) begin
				if (!row_open[slot_bank[i]]) begin
					if (act_ok[slot_bank[i]] && bg_act_ok[status.bg[i]]) begin
						slot_cmd[i] = cmd_activate;
					end
				end else if (slot_hit[i]) begin
					if (col_ok[slot_bank[i]] && bus_col_ok) begin
						slot_cmd[i] = (status.kind[i] == kind_read) ? cmd_read : cmd_write;
					end
				end else if (pre_ok[slot_bank[i]] && !hit_pending[slot_bank[i]]) begin
					slot_cmd[i] = cmd_precharge;   // row miss, keep the open row for pending hits
				end
			end
			cand[i] = slot_cmd[i] != cmd_none;
		end
	end

	always_comb begin
		found = 1'b0;
		pick = rr_ptr;
		idx = rr_ptr;
		for (int k = 0; k < no_of_bursts; k++) begin
			idx = rr_ptr + slot_idx_t'(k);   // wraps, slot count is a power of two
			if (!found && cand[idx]) begin
				found = 1'b1;
				pick = idx;
			end
		end
		next_cmd = cmd_none;
		if (issued.cmd == cmd_none && refresh_ready) begin
			if (refresh_due) begin
				if (bus_idle) begin
					next_cmd = cmd_refresh_all;   // nothing else starts while refresh is due
				end
			end else if (found) begin
				next_cmd = slot_cmd[pick];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			issued.cmd <= cmd_none;
			rr_ptr <= '0;
		end else begin
			issued.cmd <= next_cmd;
			if (next_cmd != cmd_none && next_cmd != cmd_refresh_all) begin
				rr_ptr <= pick + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (next_cmd != cmd_none) begin
			issued.slot <= pick;
			issued.bg <= status.bg[pick];
			issued.bank <= status.bank[pick];
			issued.row <= status.row[pick];
		end
	end

endmodule

// ==== hw/dram_sched_pkg.sv ====
package dram_sched_pkg;

	typedef logic [1:0] bg_t;         // bank group number
	typedef logic [1:0] bank_t;       // bank inside its group
	typedef logic [3:0] bank_id_t;    // flat bank number {bg, bank}
	typedef logic [15:0] row_t;

	typedef enum logic {
		kind_read,
		kind_write
	} req_kind_t;

	typedef enum logic [1:0] {
		slot_empty,
		slot_full,
		slot_returning    // column command sent, waiting out the data time
	} burst_state_t;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge,
		cmd_refresh_all
	} dram_cmd_t;

	localparam int bank_count = 16;
	localparam int bank_group_count = 4;

	// same bank spacing, in cycles
	localparam int act_to_col = 3;
	localparam int pre_to_act = 12;
	localparam int act_to_act_same_bank = 40;
	localparam int act_to_pre = 28;
	localparam int rd_to_pre = 6;
	localparam int wr_to_pre = 12;

	localparam int act_to_act_diff_bank = 6;    // same bank group

	// shared data bus
	localparam int rd_to_data = 23;
	localparam int wr_to_data = 22;
	localparam int col_to_col = 4;
	localparam int burst_time = 16;

	localparam int max_refresh_time = 1000;
	localparam int wait_after_refresh = 20;

endpackage

// ==== hw/dram_sched_top.sv ====
module dram_sched_top #(
	parameter int no_of_bursts = 4
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input dram_sched_pkg::req_kind_t req_kind,
	input dram_sched_pkg::bg_t req_bg,
	input dram_sched_pkg::bank_t req_bank,
	input dram_sched_pkg::row_t req_row,
	output logic req_ready,
	output dram_sched_pkg::dram_cmd_t cmd,
	output dram_sched_pkg::bg_t cmd_bg,
	output dram_sched_pkg::bank_t cmd_bank,
	output dram_sched_pkg::row_t cmd_row
);
	import dram_sched_pkg::*;

	// bank status between tracker and scheduler
	logic [bank_count-1:0] row_open;
	row_t [bank_count-1:0] open_row;
	logic [bank_count-1:0] act_ok;
	logic [bank_count-1:0] col_ok;
	logic [bank_count-1:0] pre_ok;
	logic [bank_group_count-1:0] bg_act_ok;
	logic bus_col_ok;
	logic bus_idle;
	logic refresh_ready;
	logic refresh_due;

	slot_status_if #(.no_of_bursts(no_of_bursts)) i_slot_status ();
	issued_cmd_if #(.no_of_bursts(no_of_bursts)) i_issued ();

	burst_slot_table #(.no_of_bursts(no_of_bursts)) i_slot_table (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_kind(req_kind),
		.req_bg(req_bg),
		.req_bank(req_bank),
		.req_row(req_row),
		.req_ready(req_ready),
		.status(i_slot_status.tbl),
		.issued(i_issued.listen)
	);

	bank_timing_tracker i_tracker (
		.clk(clk),
		.rst_n(rst_n),
		.issued(i_issued.listen),
		.row_open(row_open),
		.open_row(open_row),
		.act_ok(act_ok),
		.col_ok(col_ok),
		.pre_ok(pre_ok),
		.bg_act_ok(bg_act_ok),
		.bus_col_ok(bus_col_ok),
		.bus_idle(bus_idle),
		.refresh_ready(refresh_ready),
		.refresh_due(refresh_due)
	);

	dram_cmd_scheduler #(.no_of_bursts(no_of_bursts)) i_scheduler (
		.clk(clk),
		.rst_n(rst_n),
		.status(i_slot_status.sched),
		.row_open(row_open),
		.open_row(open_row),
		.act_ok(act_ok),
		.col_ok(col_ok),
		.pre_ok(pre_ok),
		.bg_act_ok(bg_act_ok),
		.bus_col_ok(bus_col_ok),
		.bus_idle(bus_idle),
		.refresh_ready(refresh_ready),
		.refresh_due(refresh_due),
		.issued(i_issued.sched)
	);

	assign cmd = i_issued.cmd;
	assign cmd_bg = i_issued.bg;
	assign cmd_bank = i_issued.bank;
	assign cmd_row = i_issued.row;

endmodule

// ==== hw/issued_cmd_if.sv ====
interface issued_cmd_if #(
	parameter int no_of_bursts = 4
);
	import dram_sched_pkg::*;

	dram_cmd_t cmd;                          // registered, one cycle after the decision
	logic [$clog2(no_of_bursts)-1:0] slot;   // slot the command was picked for
	bg_t bg;
	bank_t bank;
	row_t row;

	modport sched (
		output cmd, slot, bg, bank, row
	);

	modport listen (
		input cmd, slot, bg, bank, row
	);

endinterface

// ==== hw/slot_status_if.sv ====
interface slot_status_if #(
	parameter int no_of_bursts = 4
);
	import dram_sched_pkg::*;

	burst_state_t [no_of_bursts-1:0] state;
	req_kind_t [no_of_bursts-1:0] kind;
	bg_t [no_of_bursts-1:0] bg;
	bank_t [no_of_bursts-1:0] bank;
	row_t [no_of_bursts-1:0] row;

	// slot table side, owns the arrays
	modport tbl (
		output state, kind, bg, bank, row
	);

	modport sched (
		input state, kind, bg, bank, row
	);

endinterface

// ==== project.f ====
hw/dram_sched_pkg.sv
hw/slot_status_if.sv
hw/issued_cmd_if.sv
hw/burst_slot_table.sv
hw/bank_timing_tracker.sv
hw/dram_cmd_scheduler.sv
hw/dram_sched_top.sv
verif/tb_clk_gen.sv
verif/tb_dram_sched.sv

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen #(
	parameter int period = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;   // 50 % duty cycle
		end
	end

endmodule

// ==== verif/tb_dram_sched.sv ====
module tb_dram_sched;
	import dram_sched_pkg::*;

	localparam int num_requests = 200;
	localparam int slots = 4;
	localparam int timeout_cycles = num_requests * 100 + 5000;   // worst case plus refreshes
	localparam int rd_ret = burst_time + rd_to_data;
	localparam int wr_ret = burst_time + wr_to_data;
	localparam int max_data = (rd_to_data > wr_to_data) ? rd_to_data : wr_to_data;
	localparam int max_ref_gap = max_refresh_time + burst_time + max_data + col_to_col;
	localparam int never = -100000;
	localparam int rst_release = 3;   // first sampled cycle with reset released

	typedef struct packed {
		req_kind_t kind;
		bg_t bg;
		bank_t bank;
		row_t row;
	} req_t;

	logic clk;
	logic rst_n = 1'b1;
	logic req_valid = 1'b0;
	req_kind_t req_kind = kind_read;
	bg_t req_bg = '0;
	bank_t req_bank = '0;
	row_t req_row = '0;
	logic req_ready;
	dram_cmd_t cmd;
	bg_t cmd_bg;
	bank_t cmd_bank;
	row_t cmd_row;

	logic [31:0] lfsr = 32'h48f7;
	int cyc = 0;
	int errors = 0;
	int accepted = 0;
	int columns = 0;
	int refreshes = 0;
	int occ = 0;                          // slots the model counts as taken
	int first_act = never;
	logic prev_busy = 1'b0;               // a command was seen in the previous cycle
	int last_act [bank_count] = '{default: never};
	int last_pre [bank_count] = '{default: never};
	int last_rd [bank_count] = '{default: never};
	int last_wr [bank_count] = '{default: never};
	int last_grp_act [bank_group_count] = '{default: never};
	int last_rd_any = never;
	int last_wr_any = never;
	int last_ref = never;
	int ref_gap_start = rst_release;
	logic row_is_open [bank_count] = '{default: 1'b0};
	row_t open_row_m [bank_count];
	req_t pending[$];                     // accepted requests still waiting for a column command
	int free_at[$];                       // cycle after which a slot counts as free
	logic finished = 1'b0;
	logic timed_out = 1'b0;

	tb_clk_gen #(.period(40)) i_clk_gen (.clk(clk));

	dram_sched_top #(.no_of_bursts(slots)) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_kind(req_kind),
		.req_bg(req_bg),
		.req_bank(req_bank),
		.req_row(req_row),
		.req_ready(req_ready),
		.cmd(cmd),
		.cmd_bg(cmd_bg),
		.cmd_bank(cmd_bank),
		.cmd_row(cmd_row)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// small row pool so that hits and misses both show up
	function automatic row_t pool_row(input logic [1:0] sel);
		case (sel)
			2'd0: return 16'h0010;
			2'd1: return 16'h0a5c;
			2'd2: return 16'h1234;
			default: return 16'hbeef;
		endcase
	endfunction

	task automatic check_gap(input string what, input int now, input int last, input int min_gap);
		if (now - last < min_gap) begin
			errors++;
			$display("%s spacing broken at cycle %0d: %0d cycles, need %0d", what, now,
				now - last, min_gap);
		end
	endtask

	task automatic match_column(input req_kind_t kind, input bg_t bg, input bank_t bank,
		input row_t row);
		req_t want;
		int hit;
		want = '{kind: kind, bg: bg, bank: bank, row: row};
		hit = -1;
		for (int i = 0; i < pending.size(); i++) begin
			if (hit < 0 && pending[i] == want) begin
				hit = i;
			end
		end
		if (hit < 0) begin
			errors++;
			$display("column command at cycle %0d to group %0d bank %0d row %h has no request",
				cyc, bg, bank, row);
		end else begin
			pending.delete(hit);
		end
	endtask

	always @(posedge clk) begin
		logic [31:0] r;
		bank_id_t b;
		cyc = cyc + 1;
		if (!finished && !timed_out) begin
			if (cyc == 2) begin
				rst_n <= 1'b0;
			end
			if (cyc == 2 || cyc == 3) begin
				if (cmd !== cmd_none) begin
					errors++;
					$display("ERR cmd: got %h expected %h at cycle %0d", cmd, cmd_none, cyc);
				end
				if (req_ready !== 1'b0) begin
					errors++;
					$display("ERR req_ready: got %h expected %h at cycle %0d", req_ready, 1'b0, cyc);
				end
			end else if (cyc > 3) begin
				for (int i = free_at.size() - 1; i >= 0; i--) begin
					if (free_at[i] < cyc) begin
						free_at.delete(i);
						occ--;
					end
				end
				if (req_ready !== (occ < slots)) begin
					errors++;
					$display("ERR req_ready: got %h expected %h at cycle %0d", req_ready,
						occ < slots, cyc);
				end
				if (req_valid && req_ready) begin
					pending.push_back('{kind: req_kind, bg: req_bg, bank: req_bank, row: req_row});
					accepted++;
					occ++;
				end
				if (cmd != cmd_none && prev_busy) begin
					errors++;
					$display("commands in back to back cycles at cycle %0d", cyc);
				end
				if (cmd != cmd_none && cmd != cmd_refresh_all) begin
					check_gap("wait_after_refresh", cyc, last_ref, wait_after_refresh);
				end
				if (cyc - ref_gap_start == max_ref_gap + 1) begin
					errors++;
					$display("no refresh within %0d cycles, at cycle %0d", max_ref_gap, cyc);
				end
				b = {cmd_bg, cmd_bank};
				case (cmd)
					cmd_none: ;
					cmd_activate: begin
						if (first_act == never) begin
							first_act = cyc;
							check_gap("reset to activate", cyc, rst_release, 5);
						end
						if (row_is_open[b]) begin
							errors++;
							$display("activate to open bank %0d at cycle %0d", b, cyc);
						end
						check_gap("pre_to_act", cyc, last_pre[b], pre_to_act);
						check_gap("act_to_act_same_bank", cyc, last_act[b], act_to_act_same_bank);
						check_gap("act_to_act_diff_bank", cyc, last_grp_act[cmd_bg],
							act_to_act_diff_bank);
						row_is_open[b] = 1'b1;
						open_row_m[b] = cmd_row;
						last_act[b] = cyc;
						last_grp_act[cmd_bg] = cyc;
					end
					cmd_read, cmd_write: begin
						if (!row_is_open[b]) begin
							errors++;
							$display("column command to closed bank %0d at cycle %0d", b, cyc);
						end else if (open_row_m[b] !== cmd_row) begin
							errors++;
							$display("ERR cmd_row: got %h expected %h at cycle %0d", cmd_row,
								open_row_m[b], cyc);
						end
						check_gap("act_to_col", cyc, last_act[b], act_to_col);
						check_gap("read to column", cyc, last_rd_any, rd_ret + col_to_col);
						check_gap("write to column", cyc, last_wr_any, wr_ret + col_to_col);
						match_column(cmd == cmd_read ? kind_read : kind_write, cmd_bg, cmd_bank,
							cmd_row);
						columns++;
						free_at.push_back(cyc + ((cmd == cmd_read) ? rd_ret : wr_ret));
						if (cmd == cmd_read) begin
							last_rd[b] = cyc;
							last_rd_any = cyc;
						end else begin
							last_wr[b] = cyc;
							last_wr_any = cyc;
						end
					end
					cmd_precharge: begin
						if (!row_is_open[b]) begin
							errors++;
							$display("precharge to closed bank %0d at cycle %0d", b, cyc);
						end
						check_gap("act_to_pre", cyc, last_act[b], act_to_pre);
						check_gap("rd_to_pre", cyc, last_rd[b], rd_to_pre);
						check_gap("wr_to_pre", cyc, last_wr[b], wr_to_pre);
						row_is_open[b] = 1'b0;
						last_pre[b] = cyc;
					end
					cmd_refresh_all: begin
						check_gap("read data to refresh", cyc, last_rd_any, rd_ret);
						check_gap("write data to refresh", cyc, last_wr_any, wr_ret);
						for (int i = 0; i < bank_count; i++) begin
							row_is_open[i] = 1'b0;   // refresh closes every row
						end
						last_ref = cyc;
						ref_gap_start = cyc;
						refreshes++;
					end
					default: begin
						errors++;
						$display("cmd holds an unknown value at cycle %0d", cyc);
					end
				endcase
			end
			prev_busy = (cyc > 3) && (cmd != cmd_none);
			if (cyc >= 3) begin
				if (accepted < num_requests) begin
					take_bits(2, r);
					req_valid <= (r[1:0] != 2'b00);   // three in four cycles
					take_bits(1, r);
					req_kind <= req_kind_t'(r[0]);
					take_bits(2, r);
					req_bg <= bg_t'(r[1:0]);
					take_bits(2, r);
					req_bank <= bank_t'(r[1:0]);
					take_bits(2, r);
					req_row <= pool_row(r[1:0]);
				end else begin
					req_valid <= 1'b0;
				end
			end
			if (accepted == num_requests && pending.size() == 0 && occ == 0) begin
				finished = 1'b1;
			end else if (cyc >= timeout_cycles) begin
				timed_out = 1'b1;
			end
		end
	end

	initial begin
		wait (finished || timed_out);
		if (timed_out) begin
			errors++;
			$display("timeout after %0d cycles, %0d requests accepted, %0d still pending",
				cyc, accepted, pending.size());
		end
		$display("errors %0d, requests %0d, column commands %0d, refreshes %0d", errors,
			accepted, columns, refreshes);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
